// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

  // ====================
  // widths and base types
  // ====================
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  localparam xlen_t INSN_STEP = 32'd4;

  // ====================
  // major opcodes
  // ====================
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // alu func3 shared by register and immediate forms
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // branch func3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // jalr only has one legal func3
  localparam logic [2:0] F3_JALR = 3'b000;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // ====================
  // operation kinds
  // ====================
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU,
    BR_JAL,
    BR_JALR
  } br_op_e;

  // ====================
  // stage records
  // ====================
  typedef struct packed {
    xlen_t insn;
    xlen_t pc;
    xlen_t rs1_data;
    xlen_t rs2_data;
  } issue_t;

  typedef struct packed {
    alu_op_e  alu_op;
    br_op_e   br_op;
    xlen_t    op_a;
    xlen_t    op_b;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    pc;
    xlen_t    imm;
    reg_idx_t rd;
    logic     wb_en;
    logic     illegal;
  } dec_t;

  typedef struct packed {
    reg_idx_t rd;
    logic     wb_en;
    xlen_t    wdata;
    logic     br_taken;
    xlen_t    next_pc;
    logic     illegal;
  } res_t;

endpackage

`default_nettype wire

// File: pipe_stage.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_stage #(
  parameter type payload_t = logic [31:0]
) (
  input  wire logic clk,
  input  wire logic rst_n,

  // upstream side
  input  wire logic in_valid,
  output logic      in_ready,
  input  payload_t  in,

  // downstream side
  output logic      out_valid,
  input  wire logic out_ready,
  output payload_t  out
);

  logic load;

  // accept when empty or when the held entry leaves this cycle
  assign in_ready = ~out_valid | out_ready;
  assign load     = in_valid & in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      // drains to empty when nothing new arrives
      out_valid <= in_valid;
    end
  end

  // payload loads on every transfer
  always_ff @(posedge clk) begin
    if (load) begin
      out <= in;
    end
  end

endmodule

`default_nettype wire

// File: inst_decode.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decode (
  input  rv_pkg::issue_t issue,
  output rv_pkg::dec_t   dec
);

  // ====================
  // instruction fields
  // ====================
  logic [6:0]       opcode;
  logic [2:0]       func3;
  logic [6:0]       func7;
  rv_pkg::reg_idx_t rd;
  logic [4:0]       shamt;

  assign opcode = issue.insn[6:0];
  assign rd     = issue.insn[11:7];
  assign func3  = issue.insn[14:12];
  assign shamt  = issue.insn[24:20];
  assign func7  = issue.insn[31:25];

  logic f7_base;
  logic f7_alt;

  assign f7_base = (func7 == rv_pkg::F7_BASE);
  assign f7_alt  = (func7 == rv_pkg::F7_ALT);

  // ====================
  // immediates
  // ====================
  rv_pkg::xlen_t imm_i;
  rv_pkg::xlen_t imm_u;
  rv_pkg::xlen_t imm_b;
  rv_pkg::xlen_t imm_j;

  assign imm_i = {{20{issue.insn[31]}}, issue.insn[31:20]};
  assign imm_u = {issue.insn[31:12], 12'b0};
  assign imm_b = {{19{issue.insn[31]}}, issue.insn[31], issue.insn[7],
                  issue.insn[30:25], issue.insn[11:8], 1'b0};
  assign imm_j = {{11{issue.insn[31]}}, issue.insn[31], issue.insn[19:12],
                  issue.insn[20], issue.insn[30:21], 1'b0};

  // set for every form that produces a register value
  logic writes;

  // ====================
  // classification
  // ====================
  always_comb begin
    dec          = '0;
    dec.alu_op   = rv_pkg::ALU_ADD;
    dec.br_op    = rv_pkg::BR_NONE;
    dec.op_a     = issue.rs1_data;
    dec.op_b     = issue.rs2_data;
    dec.rs1_data = issue.rs1_data;
    dec.rs2_data = issue.rs2_data;
    dec.pc       = issue.pc;
    dec.rd       = rd;
    dec.illegal  = 1'b0;
    writes       = 1'b0;

    case (opcode)
      rv_pkg::OPC_OP: begin
        writes = 1'b1;
        case (func3)
          rv_pkg::F3_ADD_SUB: dec.alu_op = f7_alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
          rv_pkg::F3_SRL_SRA: dec.alu_op = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
          rv_pkg::F3_SLL:     dec.alu_op = rv_pkg::ALU_SLL;
          rv_pkg::F3_SLT:     dec.alu_op = rv_pkg::ALU_SLT;
          rv_pkg::F3_SLTU:    dec.alu_op = rv_pkg::ALU_SLTU;
          rv_pkg::F3_XOR:     dec.alu_op = rv_pkg::ALU_XOR;
          rv_pkg::F3_OR:      dec.alu_op = rv_pkg::ALU_OR;
          default:            dec.alu_op = rv_pkg::ALU_AND;
        endcase
        // alt func7 is valid only on add/sub and srl/sra
        // mul/div encodings fall out as illegal here
        if (f7_alt) begin
          dec.illegal = (func3 != rv_pkg::F3_ADD_SUB) && (func3 != rv_pkg::F3_SRL_SRA);
        end else begin
          dec.illegal = !f7_base;
        end
      end

      rv_pkg::OPC_OP_IMM: begin
        writes   = 1'b1;
        dec.imm  = imm_i;
        dec.op_b = imm_i;
        case (func3)
          rv_pkg::F3_ADD_SUB: dec.alu_op = rv_pkg::ALU_ADD;
          rv_pkg::F3_SLT:     dec.alu_op = rv_pkg::ALU_SLT;
          rv_pkg::F3_SLTU:    dec.alu_op = rv_pkg::ALU_SLTU;
          rv_pkg::F3_XOR:     dec.alu_op = rv_pkg::ALU_XOR;
          rv_pkg::F3_OR:      dec.alu_op = rv_pkg::ALU_OR;
          rv_pkg::F3_AND:     dec.alu_op = rv_pkg::ALU_AND;
          rv_pkg::F3_SLL: begin
            dec.alu_op  = rv_pkg::ALU_SLL;
            dec.op_b    = {27'd0, shamt};
            dec.illegal = !f7_base;
          end
          default: begin
            dec.alu_op  = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            dec.op_b    = {27'd0, shamt};
            dec.illegal = !(f7_base || f7_alt);
          end
        endcase
      end

      rv_pkg::OPC_LUI: begin
        writes     = 1'b1;
        dec.alu_op = rv_pkg::ALU_PASS_B;
        dec.op_a   = '0;
        dec.op_b   = imm_u;
        dec.imm    = imm_u;
      end

      rv_pkg::OPC_AUIPC: begin
        writes   = 1'b1;
        dec.op_a = issue.pc;
        dec.op_b = imm_u;
        dec.imm  = imm_u;
      end

      rv_pkg::OPC_JAL: begin
        // alu forms the link value
        writes    = 1'b1;
        dec.br_op = rv_pkg::BR_JAL;
        dec.op_a  = issue.pc;
        dec.op_b  = rv_pkg::INSN_STEP;
        dec.imm   = imm_j;
      end

      rv_pkg::OPC_JALR: begin
        writes      = 1'b1;
        dec.br_op   = rv_pkg::BR_JALR;
        dec.op_a    = issue.pc;
        dec.op_b    = rv_pkg::INSN_STEP;
        dec.imm     = imm_i;
        dec.illegal = (func3 != rv_pkg::F3_JALR);
      end

      rv_pkg::OPC_BRANCH: begin
        dec.imm = imm_b;
        case (func3)
          rv_pkg::F3_BEQ:  dec.br_op = rv_pkg::BR_BEQ;
          rv_pkg::F3_BNE:  dec.br_op = rv_pkg::BR_BNE;
          rv_pkg::F3_BLT:  dec.br_op = rv_pkg::BR_BLT;
          rv_pkg::F3_BGE:  dec.br_op = rv_pkg::BR_BGE;
          rv_pkg::F3_BLTU: dec.br_op = rv_pkg::BR_BLTU;
          rv_pkg::F3_BGEU: dec.br_op = rv_pkg::BR_BGEU;
          default:         dec.illegal = 1'b1;
        endcase
      end

      // loads, stores, system, fence and anything unknown
      default: dec.illegal = 1'b1;
    endcase

    // illegal records carry no jump either
    if (dec.illegal) begin
      dec.br_op = rv_pkg::BR_NONE;
    end

    dec.wb_en = writes && !dec.illegal && (rd != '0);
  end

endmodule

`default_nettype wire

// File: alu_execute.sv
`timescale 1ns/10ps
`default_nettype none

module alu_execute (
  input  rv_pkg::dec_t  dec,
  output rv_pkg::xlen_t alu_value
);

  // ====================
  // shared adder
  // ====================
  logic          sub;
  rv_pkg::xlen_t b_eff;
  rv_pkg::xlen_t sum;

  // sub as a + ~b + 1
  assign sub   = (dec.alu_op == rv_pkg::ALU_SUB);
  assign b_eff = sub ? ~dec.op_b : dec.op_b;
  assign sum   = dec.op_a + b_eff + {31'd0, sub};

  // ====================
  // compares and shifts
  // ====================
  logic lt_s;
  logic lt_u;

  assign lt_s = ($signed(dec.op_a) < $signed(dec.op_b));
  assign lt_u = (dec.op_a < dec.op_b);

  logic [4:0]    shamt;
  rv_pkg::xlen_t sll_res;
  rv_pkg::xlen_t srl_res;
  rv_pkg::xlen_t sra_res;

  // only the low five bits count on rv32
  assign shamt   = dec.op_b[4:0];
  assign sll_res = dec.op_a << shamt;
  assign srl_res = dec.op_a >> shamt;
  assign sra_res = $signed(dec.op_a) >>> shamt;

  // ====================
  // result select
  // ====================
  always_comb begin
    case (dec.alu_op)
      rv_pkg::ALU_ADD,
      rv_pkg::ALU_SUB:    alu_value = sum;
      rv_pkg::ALU_SLL:    alu_value = sll_res;
      rv_pkg::ALU_SLT:    alu_value = {31'd0, lt_s};
      rv_pkg::ALU_SLTU:   alu_value = {31'd0, lt_u};
      rv_pkg::ALU_XOR:    alu_value = dec.op_a ^ dec.op_b;
      rv_pkg::ALU_SRL:    alu_value = srl_res;
      rv_pkg::ALU_SRA:    alu_value = sra_res;
      rv_pkg::ALU_OR:     alu_value = dec.op_a | dec.op_b;
      rv_pkg::ALU_AND:    alu_value = dec.op_a & dec.op_b;
      rv_pkg::ALU_PASS_B: alu_value = dec.op_b;
      default:            alu_value = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: branch_resolve.sv
`timescale 1ns/10ps
`default_nettype none

module branch_resolve (
  input  rv_pkg::dec_t  dec,
  input  rv_pkg::xlen_t alu_value,
  output rv_pkg::res_t  res
);

  // ====================
  // operand compare
  // ====================
  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = (dec.rs1_data == dec.rs2_data);
  assign lt_s = ($signed(dec.rs1_data) < $signed(dec.rs2_data));
  assign lt_u = (dec.rs1_data < dec.rs2_data);

  logic taken;
  logic is_jump;

  always_comb begin
    case (dec.br_op)
      rv_pkg::BR_BEQ:  taken = eq;
      rv_pkg::BR_BNE:  taken = !eq;
      rv_pkg::BR_BLT:  taken = lt_s;
      rv_pkg::BR_BGE:  taken = !lt_s;
      rv_pkg::BR_BLTU: taken = lt_u;
      rv_pkg::BR_BGEU: taken = !lt_u;
      default:         taken = 1'b0;
    endcase
  end

  assign is_jump = (dec.br_op == rv_pkg::BR_JAL) || (dec.br_op == rv_pkg::BR_JALR);

  // ====================
  // target and next pc
  // ====================
  rv_pkg::xlen_t jalr_sum;
  rv_pkg::xlen_t target;

  assign jalr_sum = dec.rs1_data + dec.imm;

  // jalr drops bit 0 of the sum
  assign target = (dec.br_op == rv_pkg::BR_JALR) ? {jalr_sum[31:1], 1'b0} : dec.pc + dec.imm;

  always_comb begin
    res          = '0;
    res.rd       = dec.rd;
    res.wb_en    = dec.wb_en;
    res.wdata    = alu_value;
    res.br_taken = taken;
    res.next_pc  = (taken || is_jump) ? target : dec.pc + rv_pkg::INSN_STEP;
    res.illegal  = dec.illegal;
  end

endmodule

`default_nettype wire

// File: rv_exec_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec_top (
  input  wire logic      clk,
  input  wire logic      rst_n,

  // issue side
  input  wire logic      in_valid,
  output logic           in_ready,
  input  rv_pkg::issue_t in,

  // result side
  output logic           out_valid,
  input  wire logic      out_ready,
  output rv_pkg::res_t   out
);

  rv_pkg::dec_t  dec_d;
  rv_pkg::dec_t  dec_q;
  logic          dec_valid;
  logic          dec_ready;
  rv_pkg::xlen_t alu_value;
  rv_pkg::res_t  res_d;

  // ====================
  // decode stage
  // ====================
  inst_decode u_decode (
    .issue (in),
    .dec   (dec_d)
  );

  pipe_stage #(
    .payload_t (rv_pkg::dec_t)
  ) stage_dec (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in        (dec_d),
    .out_valid (dec_valid),
    .out_ready (dec_ready),
    .out       (dec_q)
  );

  // ====================
  // execute and resolve
  // ====================
  alu_execute u_execute (
    .dec       (dec_q),
    .alu_value (alu_value)
  );

  branch_resolve u_resolve (
    .dec       (dec_q),
    .alu_value (alu_value),
    .res       (res_d)
  );

  pipe_stage #(
    .payload_t (rv_pkg::res_t)
  ) stage_res (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (dec_valid),
    .in_ready  (dec_ready),
    .in        (res_d),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out       (out)
  );

endmodule

`default_nettype wire

// File: rv_exec_chk.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec_chk (
  input wire logic   clk,
  input wire logic   rst_n,
  input wire logic   out_valid,
  input wire logic   out_ready,
  input rv_pkg::res_t out
);

  // ====================
  // result handshake
  // ====================
  a_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high during reset");

  // stalled result keeps valid and payload
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(out))
    else $error("result changed or dropped while stalled");

  // ====================
  // record contents
  // ====================
  a_wb_needs_rd: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && out.wb_en |-> out.rd != 5'd0)
    else $error("write-back enabled for register zero");

  a_illegal_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && out.illegal |-> !out.wb_en)
    else $error("illegal record with write-back enabled");

endmodule

bind rv_exec_top rv_exec_chk chk0 (
  .clk       (clk),
  .rst_n     (rst_n),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out       (out)
);

`default_nettype wire

// File: rv_exec_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec_monitor (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     in_valid,
  input  wire logic     in_ready,
  input  rv_pkg::issue_t issue,
  input  wire logic     out_valid,
  input  wire logic     out_ready,
  input  rv_pkg::res_t  result,
  input  wire logic [2:0] phase,
  output int            value_errors,
  output int            extra_outputs,
  output int            other_errors,
  output int            pending,
  output int            stall_cycles
);

  typedef struct packed {
    rv_pkg::res_t res;
    logic         wdata_care;
    logic [2:0]   phase;
  } exp_t;

  exp_t exp_q[$];
  exp_t head;

  function automatic string phase_name(input logic [2:0] ph);
    case (ph)
      3'd1: return "reg_alu";
      3'd2: return "imm_alu";
      3'd3: return "branch";
      3'd4: return "jump";
      3'd5: return "illegal";
      3'd6: return "backpressure";
      default: return "idle";
    endcase
  endfunction

  // ====================
  // reference model
  // ====================
  function automatic rv_pkg::xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                            input rv_pkg::xlen_t a, input rv_pkg::xlen_t b);
    rv_pkg::xlen_t r;
    rv_pkg::xlen_t sra;
    sra = $signed(a) >>> b[4:0];
    case (f3)
      3'b000: r = alt ? a - b : a + b;
      3'b001: r = a << b[4:0];
      3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: r = (a < b) ? 32'd1 : 32'd0;
      3'b100: r = a ^ b;
      3'b101: r = alt ? sra : a >> b[4:0];
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic exp_t ref_result(input rv_pkg::issue_t iss, input logic [2:0] ph);
    exp_t             e;
    logic [6:0]       opc;
    logic [2:0]       f3;
    logic [6:0]       f7;
    rv_pkg::reg_idx_t rd;
    rv_pkg::xlen_t    a;
    rv_pkg::xlen_t    b;
    rv_pkg::xlen_t    imm_i;
    rv_pkg::xlen_t    imm_u;
    rv_pkg::xlen_t    imm_b;
    rv_pkg::xlen_t    imm_j;
    rv_pkg::xlen_t    target;
    logic             writes;
    logic             jump;
    logic             taken;
    logic             ill;
    opc = iss.insn[6:0];
    rd  = iss.insn[11:7];
    f3  = iss.insn[14:12];
    f7  = iss.insn[31:25];
    a   = iss.rs1_data;
    b   = iss.rs2_data;
    imm_i = {{20{iss.insn[31]}}, iss.insn[31:20]};
    imm_u = {iss.insn[31:12], 12'h000};
    imm_b = {{20{iss.insn[31]}}, iss.insn[7], iss.insn[30:25], iss.insn[11:8], 1'b0};
    imm_j = {{12{iss.insn[31]}}, iss.insn[19:12], iss.insn[20], iss.insn[30:21], 1'b0};
    e = '0;
    target = '0;
    writes = 1'b0;
    jump = 1'b0;
    taken = 1'b0;
    ill = 1'b0;
    case (opc)
      rv_pkg::OPC_OP: begin
        writes = 1'b1;
        ill = !(f7 == rv_pkg::F7_BASE || (f7 == rv_pkg::F7_ALT &&
               (f3 == rv_pkg::F3_ADD_SUB || f3 == rv_pkg::F3_SRL_SRA)));
        e.res.wdata = alu_ref(f3, f7 == rv_pkg::F7_ALT, a, b);
      end
      rv_pkg::OPC_OP_IMM: begin
        writes = 1'b1;
        if (f3 == rv_pkg::F3_SLL) ill = (f7 != rv_pkg::F7_BASE);
        if (f3 == rv_pkg::F3_SRL_SRA) ill = (f7 != rv_pkg::F7_BASE && f7 != rv_pkg::F7_ALT);
        e.res.wdata = alu_ref(f3, f3 == rv_pkg::F3_SRL_SRA && f7 == rv_pkg::F7_ALT, a, imm_i);
      end
      rv_pkg::OPC_LUI: begin
        writes = 1'b1;
        e.res.wdata = imm_u;
      end
      rv_pkg::OPC_AUIPC: begin
        writes = 1'b1;
        e.res.wdata = iss.pc + imm_u;
      end
      rv_pkg::OPC_JAL: begin
        writes = 1'b1;
        jump = 1'b1;
        e.res.wdata = iss.pc + rv_pkg::INSN_STEP;
        target = iss.pc + imm_j;
      end
      rv_pkg::OPC_JALR: begin
        writes = 1'b1;
        jump = 1'b1;
        ill = (f3 != 3'b000);
        e.res.wdata = iss.pc + rv_pkg::INSN_STEP;
        target = (a + imm_i) & ~32'h1;
      end
      rv_pkg::OPC_BRANCH: begin
        target = iss.pc + imm_b;
        case (f3)
          3'b000: taken = (a == b);
          3'b001: taken = (a != b);
          3'b100: taken = ($signed(a) < $signed(b));
          3'b101: taken = ($signed(a) >= $signed(b));
          3'b110: taken = (a < b);
          3'b111: taken = (a >= b);
          default: ill = 1'b1;
        endcase
      end
      default: ill = 1'b1;
    endcase
    if (ill) begin
      taken = 1'b0;
      jump = 1'b0;
    end
    e.res.rd = rd;
    e.res.wb_en = writes && !ill && (rd != 5'd0);
    e.res.illegal = ill;
    e.res.br_taken = taken;
    e.res.next_pc = (taken || jump) ? target : iss.pc + rv_pkg::INSN_STEP;
    // illegal and branch records carry no defined write value
    e.wdata_care = writes && !ill;
    e.phase = ph;
    return e;
  endfunction

  // ====================
  // comparison
  // ====================
  task automatic check_field(input string test, input string field,
                             input logic [31:0] exp_v, input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("Fail %s %s expected %h actual %h", test, field, exp_v, act_v);
      value_errors = value_errors + 1;
    end
  endtask

  task automatic compare_result(input exp_t e, input rv_pkg::res_t act);
    string t;
    t = phase_name(e.phase);
    check_field(t, "rd", {27'd0, e.res.rd}, {27'd0, act.rd});
    check_field(t, "wb_en", {31'd0, e.res.wb_en}, {31'd0, act.wb_en});
    check_field(t, "illegal", {31'd0, e.res.illegal}, {31'd0, act.illegal});
    check_field(t, "br_taken", {31'd0, e.res.br_taken}, {31'd0, act.br_taken});
    check_field(t, "next_pc", e.res.next_pc, act.next_pc);
    if (e.wdata_care) check_field(t, "wdata", e.res.wdata, act.wdata);
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      exp_q.delete();
      value_errors  = 0;
      extra_outputs = 0;
      other_errors  = 0;
      stall_cycles  = 0;
    end else begin
      // pop before push so an unexpected output is never masked
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("a result left the DUT with no accepted record in flight");
          extra_outputs = extra_outputs + 1;
        end else begin
          head = exp_q.pop_front();
          compare_result(head, result);
        end
      end
      if (in_valid && in_ready) exp_q.push_back(ref_result(issue, phase));
      if (in_valid && !in_ready) stall_cycles = stall_cycles + 1;
      if (!in_ready && !(out_valid && !out_ready)) begin
        $display("in_ready low although the result stage was free to drain");
        other_errors = other_errors + 1;
      end
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

// File: tb_rv_exec.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_exec;

  localparam int unsigned RESET_CYCLES   = 5;
  localparam int unsigned N_PER_PHASE    = 60;
  localparam int unsigned N_PHASES       = 6;
  localparam int unsigned TOTAL_RECORDS  = N_PER_PHASE * N_PHASES;
  localparam int unsigned TIMEOUT_CYCLES = TOTAL_RECORDS * 8 + RESET_CYCLES;

  logic           clk;
  logic           rst_n;
  logic           in_valid;
  logic           in_ready;
  rv_pkg::issue_t issue;
  logic           out_valid;
  logic           out_ready;
  rv_pkg::res_t   result;

  logic [2:0]  phase;
  logic        bp_on;
  int unsigned ready_run;
  int          seed;
  int          tb_errors;

  int value_errors;
  int extra_outputs;
  int other_errors;
  int pending;
  int stall_cycles;

  rv_exec_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in        (issue),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out       (result)
  );

  rv_exec_monitor mon0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .issue         (issue),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .result        (result),
    .phase         (phase),
    .value_errors  (value_errors),
    .extra_outputs (extra_outputs),
    .other_errors  (other_errors),
    .pending       (pending),
    .stall_cycles  (stall_cycles)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ====================
  // random helpers
  // ====================
  function automatic int unsigned pick_below(input int unsigned n);
    logic [31:0] r;
    r = $random(seed);
    return r % n;
  endfunction

  // operands lean on sign and range edges
  function automatic rv_pkg::xlen_t operand();
    logic [31:0] r;
    r = $random(seed);
    case (pick_below(8))
      0: return 32'h8000_0000;
      1: return 32'h7fff_ffff;
      2: return 32'hffff_ffff;
      3: return 32'h0000_0000;
      4: return {27'd0, r[4:0]};
      default: return r;
    endcase
  endfunction

  // one issue record of instruction class cls
  function automatic rv_pkg::issue_t make_issue(input int unsigned cls);
    rv_pkg::issue_t r;
    logic [31:0]    w;
    logic [2:0]     f3;
    logic           coin;
    w = $random(seed);
    f3 = w[14:12];
    coin = (pick_below(2) == 32'd1);
    r.pc = $random(seed);
    r.pc[1:0] = 2'b00;
    r.rs1_data = operand();
    r.rs2_data = operand();
    case (cls)
      1: begin
        w[6:0] = rv_pkg::OPC_OP;
        w[31:25] = (coin && (f3 == rv_pkg::F3_ADD_SUB || f3 == rv_pkg::F3_SRL_SRA)) ?
                   rv_pkg::F7_ALT : rv_pkg::F7_BASE;
      end
      2: begin
        case (pick_below(4))
          0: w[6:0] = rv_pkg::OPC_LUI;
          1: w[6:0] = rv_pkg::OPC_AUIPC;
          default: begin
            w[6:0] = rv_pkg::OPC_OP_IMM;
            if (f3 == rv_pkg::F3_SLL) w[31:25] = rv_pkg::F7_BASE;
            if (f3 == rv_pkg::F3_SRL_SRA) w[31:25] = coin ? rv_pkg::F7_ALT : rv_pkg::F7_BASE;
          end
        endcase
      end
      3: begin
        w[6:0] = rv_pkg::OPC_BRANCH;
        // 010 and 011 are not branches
        if (f3[2:1] == 2'b01) f3[1] = 1'b0;
        if (coin) r.rs2_data = r.rs1_data;
      end
      4: begin
        if (coin) begin
          w[6:0] = rv_pkg::OPC_JAL;
        end else begin
          w[6:0] = rv_pkg::OPC_JALR;
          f3 = rv_pkg::F3_JALR;
        end
        if (pick_below(4) == 32'd0) w[11:7] = 5'd0;
      end
      default: begin
        case (pick_below(5))
          0: begin
            // mul
            w[6:0] = rv_pkg::OPC_OP;
            w[31:25] = 7'b0000001;
          end
          1: w[6:0] = 7'b0000011;
          2: begin
            // csrrw
            w[6:0] = 7'b1110011;
            f3 = 3'b001;
          end
          3: begin
            w[6:0] = rv_pkg::OPC_OP_IMM;
            f3 = rv_pkg::F3_SLL;
            w[31:25] = rv_pkg::F7_ALT;
          end
          default: w[6:0] = 7'b0100011;
        endcase
      end
    endcase
    w[14:12] = f3;
    if (pick_below(8) == 32'd0) w[11:7] = 5'd0;
    if (cls == 32'd2 && pick_below(16) == 32'd0) w = 32'h0000_0013;
    r.insn = w;
    return r;
  endfunction

  // ====================
  // drive tasks
  // ====================
  task automatic set_ready();
    if (!bp_on) begin
      out_ready = 1'b1;
    end else begin
      if (ready_run == 0) begin
        out_ready = ~out_ready;
        ready_run = pick_below(5) + 1;
      end
      ready_run = ready_run - 1;
    end
  endtask

  // entered just after a falling edge, leaves on one
  task automatic drive_record(input rv_pkg::issue_t rec);
    int unsigned gap;
    logic        done;
    gap = pick_below(3);
    repeat (gap) begin
      in_valid = 1'b0;
      set_ready();
      @(posedge clk);
      @(negedge clk);
    end
    in_valid = 1'b1;
    issue = rec;
    done = 1'b0;
    while (!done) begin
      set_ready();
      @(posedge clk);
      done = in_ready;
      @(negedge clk);
    end
    in_valid = 1'b0;
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    seed      = 32'hc358_369d;
    tb_errors = 0;
    phase     = 3'd0;
    bp_on     = 1'b0;
    ready_run = 0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    issue     = '0;
    out_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int p = 1; p <= 6; p++) begin
      phase = 3'(p);
      bp_on = (p == 6);
      repeat (N_PER_PHASE) begin
        // the last phase mixes every class
        if (p == 6) drive_record(make_issue(pick_below(5) + 1));
        else drive_record(make_issue(32'(p)));
      end
    end

    bp_on = 1'b0;
    while (pending != 0) begin
      set_ready();
      @(negedge clk);
    end
    repeat (4) @(negedge clk);

    if (stall_cycles == 0) begin
      $display("back-pressure phase never stalled the issue side");
      tb_errors = tb_errors + 1;
    end

    $display("errors: value %0d, unexpected outputs %0d, other %0d, testbench %0d, left %0d",
             value_errors, extra_outputs, other_errors, tb_errors, pending);
    if (value_errors == 0 && extra_outputs == 0 && other_errors == 0 &&
        tb_errors == 0 && pending == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("run timed out after %0d cycles, %0d records still in flight",
             TIMEOUT_CYCLES, pending);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
rv_pkg.sv
pipe_stage.sv
inst_decode.sv
alu_execute.sv
branch_resolve.sv
rv_exec_top.sv
rv_exec_chk.sv
rv_exec_monitor.sv
tb_rv_exec.sv

// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_rv_exec
FILELIST ?= src.f

BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and fail if the log reports a failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
